// File: hdl/vn_lut_pkg.sv
`default_nettype none

package vn_lut_pkg;

	// Message and table widths
	localparam int QUAN_SIZE       = 3;
	localparam int LUT_PORT_SIZE   = 3;
	localparam int ENTRY_ADDR      = 5;
	localparam int MULTI_FRAME_NUM = 2;
	localparam int PAGE_W          = ENTRY_ADDR - $clog2(MULTI_FRAME_NUM);
	localparam int NUM_PORTS       = 4;

	// AXI4-Lite
	localparam int         AXI_ADDR_W  = 8;
	localparam int         AXI_DATA_W  = 32;
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// One variable-node unit input, y0 msb is the sign
	typedef struct packed {
		logic                 transpose_en;
		logic [QUAN_SIZE-1:0] y0;
		logic [QUAN_SIZE-1:0] y1;
	} vn_msg_t;

	// Towards the decision stage
	typedef struct packed {
		logic [QUAN_SIZE-1:0] t_c;
		logic [QUAN_SIZE-1:0] t_c_din;
		logic                 transpose_en;
	} vn_ch_out_t;

	typedef struct packed {
		logic [PAGE_W-1:0] page;
		logic              bank;
	} lut_addr_t;

	// Same page and offset in both banks
	typedef struct packed {
		logic                     we;
		logic [PAGE_W-1:0]        page;
		logic                     offset;
		logic [LUT_PORT_SIZE-1:0] data0;
		logic [LUT_PORT_SIZE-1:0] data1;
	} lut_wr_t;

endpackage

`default_nettype wire

// File: hdl/vn_addr_bus.sv
`timescale 1ns/1ps
`default_nettype none

module vn_addr_bus
	import vn_lut_pkg::*;
(
	input  wire [QUAN_SIZE-2:0] y0_low,
	input  wire [QUAN_SIZE-1:0] y1,
	output lut_addr_t           addr
);

	// Stored half table layout
	// bank from the lowest y1 bit, page from what is left
	always_comb begin
		addr.bank = y1[0];
		addr.page = {y0_low, y1[QUAN_SIZE-1:1]};
	end

endmodule

`default_nettype wire

// File: hdl/vn_lut_rank.sv
`timescale 1ns/1ps
`default_nettype none

module vn_lut_rank
	import vn_lut_pkg::*;
(
	input  wire                                          read_clk,
	input  wire lut_addr_t [NUM_PORTS-1:0]               rd_addr,
	input  wire                                          rd_offset,
	output logic [NUM_PORTS-1:0][LUT_PORT_SIZE-1:0]      rd_data,
	input  wire lut_wr_t                                 wr
);

	// Two frames of pages per bank, frame offset on top
	logic [LUT_PORT_SIZE-1:0] bank0_mem [1 << ENTRY_ADDR];
	logic [LUT_PORT_SIZE-1:0] bank1_mem [1 << ENTRY_ADDR];

	////////////////////
	// Write port

	// One request fills both banks
	always_ff @(posedge read_clk) begin
		if (wr.we) begin
			bank0_mem[{wr.offset, wr.page}] <= wr.data0;
			bank1_mem[{wr.offset, wr.page}] <= wr.data1;
		end
	end

	////////////////////
	// Read ports

	// All ports share the frame offset
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (rd_addr[i].bank) begin
				rd_data[i] = bank1_mem[{rd_offset, rd_addr[i].page}];
			end else begin
				rd_data[i] = bank0_mem[{rd_offset, rd_addr[i].page}];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/sym_vn_lut_out.sv
`timescale 1ns/1ps
`default_nettype none

module sym_vn_lut_out
	import vn_lut_pkg::*;
(
	input  wire                           read_clk,
	input  wire                           rst_n,
	input  wire vn_msg_t [NUM_PORTS-1:0]  msg_in,
	input  wire                           read_addr_offset,
	input  wire lut_wr_t                  wr,
	output vn_ch_out_t [NUM_PORTS-1:0]    ch_out,
	output logic                          read_addr_offset_out
);

	// Folded message pair of one port
	typedef struct packed {
		logic                 msb;
		logic [QUAN_SIZE-2:0] y0_low;
		logic [QUAN_SIZE-1:0] y1;
	} fold_t;

	fold_t [NUM_PORTS-1:0]                  fold;
	fold_t [NUM_PORTS-1:0]                  fold_p0;
	logic                                   offset_p0;
	lut_addr_t [NUM_PORTS-1:0]              rd_addr;
	logic [NUM_PORTS-1:0][LUT_PORT_SIZE-1:0] lut_out;
	logic [NUM_PORTS-1:0][LUT_PORT_SIZE-1:0] lut_out_p1;
	logic [NUM_PORTS-1:0]                   msb_p1;
	logic                                   offset_p1;

	////////////////////
	// Fold onto the stored half

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			fold[i].msb    = msg_in[i].transpose_en ^ msg_in[i].y0[QUAN_SIZE-1];
			// Magnitude bits flipped by the sign
			fold[i].y0_low = msg_in[i].y0[QUAN_SIZE-2:0] ^
				{(QUAN_SIZE-1){msg_in[i].y0[QUAN_SIZE-1]}};
			fold[i].y1     = fold[i].msb ? ~msg_in[i].y1 : msg_in[i].y1;
		end
	end

	// Stage 0
	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			fold_p0   <= '0;
			offset_p0 <= 1'b0;
		end else begin
			fold_p0   <= fold;
			offset_p0 <= read_addr_offset;
		end
	end

	////////////////////
	// Address mapping and table read

	for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_addr
		vn_addr_bus u_addr_bus (
			.y0_low (fold_p0[gi].y0_low),
			.y1     (fold_p0[gi].y1),
			.addr   (rd_addr[gi])
		);
	end

	vn_lut_rank u_lut_rank (
		.read_clk  (read_clk),
		.rd_addr   (rd_addr),
		.rd_offset (offset_p0),
		.rd_data   (lut_out),
		.wr        (wr)
	);

	// Stage 1, fold flag and offset follow the entries
	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			lut_out_p1 <= '0;
			msb_p1     <= '0;
			offset_p1  <= 1'b0;
		end else begin
			lut_out_p1 <= lut_out;
			for (int i = 0; i < NUM_PORTS; i++) begin
				msb_p1[i] <= fold_p0[i].msb;
			end
			offset_p1 <= offset_p0;
		end
	end

	////////////////////
	// Unfold

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			ch_out[i].t_c          = msb_p1[i] ? ~lut_out_p1[i] : lut_out_p1[i];
			// Decision node wants the raw entry
			ch_out[i].t_c_din      = lut_out_p1[i];
			ch_out[i].transpose_en = msb_p1[i];
		end
	end

	assign read_addr_offset_out = offset_p1;

endmodule

`default_nettype wire

// File: hdl/vn_lut_axil_wr.sv
`timescale 1ns/1ps
`default_nettype none

module vn_lut_axil_wr
	import vn_lut_pkg::*;
(
	input  wire                   read_clk,
	input  wire                   rst_n,
	// Write address, data and response
	input  wire  [AXI_ADDR_W-1:0] awaddr,
	input  wire                   awvalid,
	output logic                  awready,
	input  wire  [AXI_DATA_W-1:0] wdata,
	input  wire                   wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  wire                   bready,
	// Read channel of a write-only table
	input  wire  [AXI_ADDR_W-1:0] araddr,
	input  wire                   arvalid,
	output logic                  arready,
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  wire                   rready,
	output lut_wr_t               wr
);

	logic                     aw_start;
	logic                     wr_accept;
	logic                     addr_bad;
	logic                     we_q;
	logic [PAGE_W-1:0]        page_q;
	logic                     offset_q;
	logic [LUT_PORT_SIZE-1:0] data0_q;
	logic [LUT_PORT_SIZE-1:0] data1_q;

	// Open both channels only while no response is pending
	assign aw_start  = awvalid & wvalid & ~awready & ~bvalid;
	assign wr_accept = awready & awvalid & wready & wvalid;
	assign addr_bad  = awaddr > 8'h7f;

	////////////////////
	// Write path

	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= RESP_OKAY;
			we_q    <= 1'b0;
		end else begin
			awready <= aw_start;
			wready  <= aw_start;
			we_q    <= wr_accept & ~addr_bad;
			if (wr_accept) begin
				bvalid <= 1'b1;
				bresp  <= addr_bad ? RESP_SLVERR : RESP_OKAY;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Page in bits 5..2, frame offset in bit 6
	always_ff @(posedge read_clk) begin
		if (wr_accept) begin
			page_q   <= awaddr[PAGE_W+1:2];
			offset_q <= awaddr[PAGE_W+2];
			data0_q  <= wdata[LUT_PORT_SIZE-1:0];
			data1_q  <= wdata[2*LUT_PORT_SIZE-1:LUT_PORT_SIZE];
		end
	end

	assign wr = '{we: we_q, page: page_q, offset: offset_q, data0: data0_q, data1: data1_q};

	////////////////////
	// Read path

	// Any address is refused the same way
	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid & ~arready & ~rvalid;
			if (arready & arvalid) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	assign rdata = '0;
	assign rresp = RESP_SLVERR;

endmodule

`default_nettype wire

// File: hdl/vn_lut_top.sv
`timescale 1ns/1ps
`default_nettype none

module vn_lut_top
	import vn_lut_pkg::*;
(
	input  wire                           read_clk,
	input  wire                           rst_n,
	// AXI4-Lite slave
	input  wire  [AXI_ADDR_W-1:0]         awaddr,
	input  wire                           awvalid,
	output logic                          awready,
	input  wire  [AXI_DATA_W-1:0]         wdata,
	input  wire                           wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  wire                           bready,
	input  wire  [AXI_ADDR_W-1:0]         araddr,
	input  wire                           arvalid,
	output logic                          arready,
	output logic [AXI_DATA_W-1:0]         rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  wire                           rready,
	// Lookup
	input  wire vn_msg_t [NUM_PORTS-1:0]  msg_in,
	input  wire                           read_addr_offset,
	output vn_ch_out_t [NUM_PORTS-1:0]    ch_out,
	output logic                          read_addr_offset_out
);

	lut_wr_t lut_wr;

	vn_lut_axil_wr u_axil_wr (
		.read_clk (read_clk),
		.rst_n    (rst_n),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.wr       (lut_wr)
	);

	sym_vn_lut_out u_lut_out (
		.read_clk             (read_clk),
		.rst_n                (rst_n),
		.msg_in               (msg_in),
		.read_addr_offset     (read_addr_offset),
		.wr                   (lut_wr),
		.ch_out               (ch_out),
		.read_addr_offset_out (read_addr_offset_out)
	);

endmodule

`default_nettype wire

// File: tests/tb_vn_lut_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vn_lut_top
	import vn_lut_pkg::*;
();

	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT  = 50;

	// Offset, then ports 3 down to 0, each {transpose, y0, y1}
	typedef struct packed {
		logic                    offset;
		vn_msg_t [NUM_PORTS-1:0] msg;
	} row_t;

	// Rows 0 and 1 hold pairs that fold onto one stored entry
	localparam row_t STIM [NUM_ROWS] = '{
		{1'b0, 7'b0_000_000, 7'b0_000_001, 7'b1_111_000, 7'b1_111_001},
		{1'b0, 7'b0_000_011, 7'b0_111_100, 7'b1_011_100, 7'b1_100_011},
		{1'b1, 7'b0_010_110, 7'b1_010_110, 7'b0_110_001, 7'b1_110_001},
		{1'b1, 7'b0_001_111, 7'b0_101_000, 7'b1_001_000, 7'b1_101_111},
		{1'b0, 7'b0_011_010, 7'b1_100_101, 7'b0_100_101, 7'b1_011_010},
		{1'b1, 7'b0_111_111, 7'b1_000_000, 7'b0_000_111, 7'b1_111_000},
		{1'b0, 7'b0_101_011, 7'b0_010_100, 7'b1_110_110, 7'b1_001_001},
		{1'b1, 7'b0_011_001, 7'b0_100_110, 7'b1_000_101, 7'b1_111_010}
	};

	logic                       read_clk;
	logic                       rst_n;
	logic [AXI_ADDR_W-1:0]      awaddr;
	logic                       awvalid;
	logic                       awready;
	logic [AXI_DATA_W-1:0]      wdata;
	logic                       wvalid;
	logic                       wready;
	logic [1:0]                 bresp;
	logic                       bvalid;
	logic                       bready;
	logic [AXI_ADDR_W-1:0]      araddr;
	logic                       arvalid;
	logic                       arready;
	logic [AXI_DATA_W-1:0]      rdata;
	logic [1:0]                 rresp;
	logic                       rvalid;
	logic                       rready;
	vn_msg_t [NUM_PORTS-1:0]    msg_in;
	logic                       read_addr_offset;
	vn_ch_out_t [NUM_PORTS-1:0] ch_out;
	logic                       read_addr_offset_out;

	// Shadow of the table, indexed by {offset, page}
	logic [LUT_PORT_SIZE-1:0] shadow0 [1 << ENTRY_ADDR];
	logic [LUT_PORT_SIZE-1:0] shadow1 [1 << ENTRY_ADDR];
	logic [31:0]              lfsr_state;
	int                       test_errors;
	int                       errors;
	int                       tests_run;
	int                       tests_failed;

	vn_lut_top u_vn_lut_top (.*);

	initial begin
		read_clk = 1'b0;
		forever #2 read_clk = ~read_clk;
	end

	////////////////////
	// Helpers

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [LUT_PORT_SIZE-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[LUT_PORT_SIZE-2:0], lfsr_state[0]};
		end
	endtask

	// Fold, look up the shadow table, unfold
	function automatic vn_ch_out_t lookup_model(input vn_msg_t m, input logic off);
		logic                     sign;
		logic                     msb;
		logic [1:0]               y0_low;
		logic [QUAN_SIZE-1:0]     y1_f;
		logic [ENTRY_ADDR-1:0]    idx;
		logic [LUT_PORT_SIZE-1:0] entry;
		vn_ch_out_t               o;
		sign   = m.y0[2];
		y0_low = m.y0[1:0] ^ {2{sign}};
		msb    = m.transpose_en ^ sign;
		y1_f   = msb ? ~m.y1 : m.y1;
		idx    = {off, y0_low, y1_f[2:1]};
		entry  = y1_f[0] ? shadow1[idx] : shadow0[idx];
		o.t_c          = msb ? ~entry : entry;
		o.t_c_din      = entry;
		o.transpose_en = msb;
		return o;
	endfunction

	task automatic drive_row(input int r);
		msg_in           <= STIM[r].msg;
		read_addr_offset <= STIM[r].offset;
	endtask

	task automatic check_row(input int r);
		vn_ch_out_t want;
		for (int p = 0; p < NUM_PORTS; p++) begin
			want = lookup_model(STIM[r].msg[p], STIM[r].offset);
			if (ch_out[p].t_c !== want.t_c) begin
				$display("Mismatch row %0d port %0d t_c: got %h, expected %h",
					r, p, ch_out[p].t_c, want.t_c);
				test_errors++;
			end
			if (ch_out[p].t_c_din !== want.t_c_din) begin
				$display("Mismatch row %0d port %0d t_c_din: got %h, expected %h",
					r, p, ch_out[p].t_c_din, want.t_c_din);
				test_errors++;
			end
			if (ch_out[p].transpose_en !== want.transpose_en) begin
				$display("Mismatch row %0d port %0d transpose_en: got %h, expected %h",
					r, p, ch_out[p].transpose_en, want.transpose_en);
				test_errors++;
			end
		end
		if (read_addr_offset_out !== STIM[r].offset) begin
			$display("Mismatch row %0d read_addr_offset_out: got %h, expected %h",
				r, read_addr_offset_out, STIM[r].offset);
			test_errors++;
		end
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
			input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
		int n;
		@(posedge read_clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (!(awready && wready) && n < TIMEOUT);
		if (!(awready && wready)) begin
			$display("Write to %h was never accepted", addr);
			test_errors++;
		end
		@(posedge read_clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (!bvalid && n < TIMEOUT);
		if (!bvalid) begin
			$display("No write response for address %h", addr);
			test_errors++;
		end
		resp = bresp;
		// Table entry is committed on this edge
		@(posedge read_clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read_check(input logic [AXI_ADDR_W-1:0] addr);
		int n;
		@(posedge read_clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (!arready && n < TIMEOUT);
		if (!arready) begin
			$display("Read of %h was never accepted", addr);
			test_errors++;
		end
		@(posedge read_clk);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge read_clk);
			n++;
		end while (!rvalid && n < TIMEOUT);
		if (!rvalid) begin
			$display("No read response for address %h", addr);
			test_errors++;
		end
		if (rresp !== RESP_SLVERR) begin
			$display("Mismatch rresp: got %h, expected %h", rresp, RESP_SLVERR);
			test_errors++;
		end
		if (rdata !== '0) begin
			$display("Mismatch rdata: got %h, expected %h", rdata, 32'h0);
			test_errors++;
		end
		// Response held while rready stays low
		repeat (3) begin
			@(negedge read_clk);
			if (!rvalid) begin
				$display("Read response dropped before rready");
				test_errors++;
			end
		end
		@(posedge read_clk);
		rready <= 1'b1;
		@(posedge read_clk);
		rready <= 1'b0;
		@(negedge read_clk);
		if (rvalid) begin
			$display("Read response still valid after rready");
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors > 0) begin
			tests_failed++;
		end
		errors += test_errors;
		$display("Test %0d %s: %s, %0d errors", tests_run, name,
			(test_errors > 0) ? "FAILED" : "ok", test_errors);
		test_errors = 0;
	endtask

	////////////////////
	// Test sequence

	initial begin
		logic [1:0]               resp;
		logic [LUT_PORT_SIZE-1:0] d0;
		logic [LUT_PORT_SIZE-1:0] d1;
		rst_n            = 1'b0;
		awaddr           = '0;
		awvalid          = 1'b0;
		wdata            = '0;
		wvalid           = 1'b0;
		bready           = 1'b0;
		araddr           = '0;
		arvalid          = 1'b0;
		rready           = 1'b0;
		msg_in           = '0;
		read_addr_offset = 1'b0;
		lfsr_state       = 32'hbbda;
		test_errors      = 0;
		errors           = 0;
		tests_run        = 0;
		tests_failed     = 0;
		repeat (5) @(posedge read_clk);
		rst_n <= 1'b1;

		@(negedge read_clk);
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (ch_out[p] !== '0) begin
				$display("Mismatch ch_out[%0d]: got %h, expected %h", p, ch_out[p], 7'h0);
				test_errors++;
			end
		end
		if (read_addr_offset_out !== 1'b0) begin
			$display("Mismatch read_addr_offset_out: got %h, expected 0", read_addr_offset_out);
			test_errors++;
		end
		if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
			$display("Mismatch bvalid/rvalid: got %h/%h, expected 0/0", bvalid, rvalid);
			test_errors++;
		end
		finish_test("reset values");

		// Both frames, address bit 6 is the frame offset
		for (int i = 0; i < 2 * 16; i++) begin
			draw_bits(LUT_PORT_SIZE, d0);
			draw_bits(LUT_PORT_SIZE, d1);
			axi_write({1'b0, i[4:0], 2'b00}, {26'd0, d1, d0}, resp);
			shadow0[i[4:0]] = d0;
			shadow1[i[4:0]] = d1;
			if (resp !== RESP_OKAY) begin
				$display("Mismatch bresp page %0d: got %h, expected %h", i, resp, RESP_OKAY);
				test_errors++;
			end
		end
		finish_test("table programming");

		for (int r = 0; r < NUM_ROWS; r++) begin
			@(posedge read_clk);
			drive_row(r);
			repeat (2) @(posedge read_clk);
			@(negedge read_clk);
			check_row(r);
		end
		finish_test("single rows");

		// Row k-2 shows up while row k is applied
		for (int k = 0; k < NUM_ROWS + 2; k++) begin
			@(posedge read_clk);
			if (k < NUM_ROWS) begin
				drive_row(k);
			end
			@(negedge read_clk);
			if (k >= 2) begin
				check_row(k - 2);
			end
		end
		finish_test("back to back rows");

		// 0x80 would land on frame 0 page 0, which row 0 reads
		axi_write(8'h80, {26'd0, ~shadow1[0], ~shadow0[0]}, resp);
		if (resp !== RESP_SLVERR) begin
			$display("Mismatch bresp: got %h, expected %h", resp, RESP_SLVERR);
			test_errors++;
		end
		@(posedge read_clk);
		drive_row(0);
		repeat (2) @(posedge read_clk);
		@(negedge read_clk);
		check_row(0);
		finish_test("out of range write");

		axi_read_check(8'h04);
		finish_test("read refused");

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hdl/vn_lut_pkg.sv
hdl/vn_addr_bus.sv
hdl/vn_lut_rank.sv
hdl/sym_vn_lut_out.sv
hdl/vn_lut_axil_wr.sv
hdl/vn_lut_top.sv
tests/tb_vn_lut_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vn_lut_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
